// ==== include/pic_defines.svh ====
`ifndef PIC_DEFINES_SVH
`define PIC_DEFINES_SVH

// --------------------
// Datapath widths
`define PIC_DATA_W      8     // Register file byte
`define PIC_PC_W        13    // Program counter, 8K words
`define PIC_INST_W      14    // Instruction word
`define PIC_RAM_ADR_W   9     // Bank bits plus 7-bit offset

// --------------------
// PC stack
`define PIC_STACK_DEPTH 8
`define PIC_STACK_PTR_W 3     // Wraps at depth

// --------------------
// Special registers, offsets within a bank
`define PIC_ADR_PCL     7'h02
`define PIC_ADR_STATUS  7'h03
`define PIC_ADR_FSR     7'h04
`define PIC_ADR_PCLATH  7'h0A
`define PIC_FIRST_GPR   7'h0C // External RAM from here up

`define PIC_RESET_PC    13'h0000

`endif

// ==== hdl/pic_pkg.sv ====
`include "pic_defines.svh"

package pic_pkg;

  // Plain vectors
  typedef logic [`PIC_DATA_W-1:0]      data_t;
  typedef logic [`PIC_PC_W-1:0]        pc_t;
  typedef logic [`PIC_INST_W-1:0]      inst_t;
  typedef logic [`PIC_RAM_ADR_W-1:0]   ram_adr_t;
  typedef logic [`PIC_STACK_PTR_W-1:0] stack_ptr_t;

  // Two clocks per instruction cycle
  typedef enum logic {PH_Q2, PH_Q4} phase_e;

  // Kept opcodes; RETFIE and SLEEP fall into NOP
  typedef enum logic [4:0] {
    OP_NOP,    OP_ADDLW,  OP_ADDWF,  OP_ANDLW,  OP_ANDWF,  OP_BCF,
    OP_BSF,    OP_BTFSC,  OP_BTFSS,  OP_CALL,   OP_CLRF,   OP_CLRW,
    OP_COMF,   OP_DECF,   OP_DECFSZ, OP_GOTO,   OP_INCF,   OP_INCFSZ,
    OP_IORLW,  OP_IORWF,  OP_MOVLW,  OP_MOVF,   OP_MOVWF,  OP_RETLW,
    OP_RETURN, OP_RLF,    OP_RRF,    OP_SUBLW,  OP_SUBWF,  OP_SWAPF,
    OP_XORLW,  OP_XORWF
  } op_e;

  // How fetch picks the next PC
  typedef enum logic [1:0] {RD_NONE, RD_JUMP, RD_RETURN, RD_PCL} redirect_e;

  typedef struct packed {
    op_e        op;
    logic       dest_w;      // Result goes to W
    logic       dest_f;      // Result goes to file register
    logic [6:0] file;        // Register offset, 0 means indirect
    logic [2:0] bit_idx;     // BCF/BSF/BTFSx bit
    data_t      literal;     // k field
    logic       push;        // CALL
    logic       pop;         // RETURN, RETLW
  } decoded_s;

  typedef struct packed {
    data_t alu_a;
    data_t alu_b;
    logic  sub_zero_c;       // Subtracting zero forces C
    logic  sub_zero_dc;      // Low nibble zero forces DC
    logic  tgt_pcl;
    logic  tgt_status;
    logic  tgt_fsr;
    logic  tgt_pclath;
  } operand_s;

  typedef struct packed {
    redirect_e kind;
    logic      skip_stall;   // Taken skip, PC just steps
    data_t     new_pcl;      // Low PC byte on a PCL write
  } redirect_s;

endpackage

// ==== hdl/pic_fetch.sv ====
`include "pic_defines.svh"

module pic_fetch (
  input  logic               clk_i,
  input  logic               reset_i,
  input  pic_pkg::inst_t     prog_dat_i,   // ROM data
  input  pic_pkg::decoded_s  dec_i,
  input  pic_pkg::redirect_s redirect_i,
  input  logic               stall_i,
  input  pic_pkg::data_t     pclath_i,
  output pic_pkg::pc_t       prog_adr_o,   // ROM address
  output pic_pkg::inst_t     inst_o,
  output pic_pkg::phase_e    phase_o
);
  import pic_pkg::*;

  pc_t        pc_q;                        // Address being fetched
  pc_t        next_pc;
  inst_t      inst_q;                      // Instruction being executed
  phase_e     phase_q;
  pc_t        stack_q [`PIC_STACK_DEPTH];
  stack_ptr_t sp_q;
  pc_t        stack_top;

  assign stack_top = stack_q[sp_q];        // Already popped at Q2

  // --------------------
  // Next PC selection
  always_comb
  begin
    case (redirect_i.kind)
      RD_RETURN: next_pc = stack_top;
      RD_JUMP:   next_pc = {pclath_i[4:3], inst_q[10:0]};    // 2K page from PCLATH
      RD_PCL:    next_pc = {pclath_i[4:0], redirect_i.new_pcl};
      default:   next_pc = pc_q + 1'b1;    // Also on stall and taken skip
    endcase
  end

  // --------------------
  // Phase, PC, IR and stack pointer
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      phase_q <= PH_Q2;
      pc_q    <= `PIC_RESET_PC;
      inst_q  <= '0;                       // NOP
      sp_q    <= '0;
    end
    else
    begin
      phase_q <= (phase_q == PH_Q2) ? PH_Q4 : PH_Q2;
      if (phase_q == PH_Q4)
      begin
        pc_q   <= next_pc;
        inst_q <= prog_dat_i;              // Fetch overlaps execution
        if (dec_i.push && !stall_i)
          sp_q <= sp_q + 1'b1;             // Push on CALL
      end
      else if (dec_i.pop && !stall_i)
        sp_q <= sp_q - 1'b1;               // Pop early, top ready by Q4
    end
  end

  // Stack entries, return address is the PC in flight
  always_ff @(posedge clk_i)
  begin
    if (phase_q == PH_Q4 && dec_i.push && !stall_i)
      stack_q[sp_q] <= pc_q;
  end

  assign prog_adr_o = pc_q;
  assign inst_o     = inst_q;
  assign phase_o    = phase_q;

endmodule

// ==== hdl/pic_decode.sv ====
module pic_decode (
  input  pic_pkg::inst_t    inst_i,
  output pic_pkg::decoded_s dec_o
);
  import pic_pkg::*;

  always_comb
  begin
    dec_o         = '0;
    dec_o.file    = inst_i[6:0];
    dec_o.bit_idx = inst_i[9:7];
    dec_o.literal = inst_i[7:0];

    // --------------------
    // Opcode prefixes, anything unmatched is NOP
    casez (inst_i)
      14'b100???????????: dec_o.op = OP_CALL;
      14'b101???????????: dec_o.op = OP_GOTO;
      14'b0100??????????: dec_o.op = OP_BCF;
      14'b0101??????????: dec_o.op = OP_BSF;
      14'b0110??????????: dec_o.op = OP_BTFSC;
      14'b0111??????????: dec_o.op = OP_BTFSS;
      14'b1100??????????: dec_o.op = OP_MOVLW;
      14'b1101??????????: dec_o.op = OP_RETLW;
      14'b11110?????????: dec_o.op = OP_SUBLW;
      14'b11111?????????: dec_o.op = OP_ADDLW;
      14'b111000????????: dec_o.op = OP_IORLW;
      14'b111001????????: dec_o.op = OP_ANDLW;
      14'b111010????????: dec_o.op = OP_XORLW;
      14'b000010????????: dec_o.op = OP_SUBWF;
      14'b000011????????: dec_o.op = OP_DECF;
      14'b000100????????: dec_o.op = OP_IORWF;
      14'b000101????????: dec_o.op = OP_ANDWF;
      14'b000110????????: dec_o.op = OP_XORWF;
      14'b000111????????: dec_o.op = OP_ADDWF;
      14'b001000????????: dec_o.op = OP_MOVF;
      14'b001001????????: dec_o.op = OP_COMF;
      14'b001010????????: dec_o.op = OP_INCF;
      14'b001011????????: dec_o.op = OP_DECFSZ;
      14'b001100????????: dec_o.op = OP_RRF;
      14'b001101????????: dec_o.op = OP_RLF;
      14'b001110????????: dec_o.op = OP_SWAPF;
      14'b001111????????: dec_o.op = OP_INCFSZ;
      14'b0000001???????: dec_o.op = OP_MOVWF;
      14'b0000010???????: dec_o.op = OP_CLRW;
      14'b0000011???????: dec_o.op = OP_CLRF;
      14'b00000000001000: dec_o.op = OP_RETURN;
      default:            dec_o.op = OP_NOP;   // Incl. RETFIE, SLEEP
    endcase

    // Destination
    case (dec_o.op)
      OP_MOVLW, OP_ADDLW, OP_SUBLW, OP_ANDLW, OP_IORLW, OP_XORLW,
      OP_RETLW, OP_CLRW:
        dec_o.dest_w = 1'b1;
      OP_MOVWF, OP_BCF, OP_BSF, OP_CLRF:
        dec_o.dest_f = 1'b1;
      OP_MOVF, OP_SWAPF, OP_ADDWF, OP_SUBWF, OP_ANDWF, OP_IORWF, OP_XORWF,
      OP_DECF, OP_INCF, OP_RLF, OP_RRF, OP_DECFSZ, OP_INCFSZ, OP_COMF:
      begin
        dec_o.dest_w = ~inst_i[7];             // d bit
        dec_o.dest_f =  inst_i[7];
      end
      default: ;                               // Control ops write nothing
    endcase

    dec_o.push = (dec_o.op == OP_CALL);
    dec_o.pop  = (dec_o.op == OP_RETURN) || (dec_o.op == OP_RETLW);
  end

endmodule

// ==== hdl/pic_operand.sv ====
`include "pic_defines.svh"

module pic_operand (
  input  logic              clk_i,
  input  logic              reset_i,
  input  pic_pkg::phase_e   phase_i,
  input  logic              stall_i,
  input  pic_pkg::decoded_s dec_i,
  input  pic_pkg::data_t    ram_dat_i,   // RAM read data
  input  pic_pkg::data_t    w_i,
  input  pic_pkg::data_t    status_i,
  input  pic_pkg::data_t    fsr_i,
  input  pic_pkg::data_t    pclath_i,
  input  pic_pkg::pc_t      pc_i,
  output pic_pkg::operand_s opnd_o,
  output pic_pkg::ram_adr_t ram_adr_o,   // Bits 8:7 carry the bank
  output logic              ram_we_o
);
  import pic_pkg::*;

  ram_adr_t   ram_adr;
  logic [6:0] offset;
  logic       addr_sram;
  logic       addr_pcl;
  logic       addr_status;
  logic       addr_fsr;
  logic       addr_pclath;
  data_t      rd_data;                   // RAM or special register
  data_t      mask;
  operand_s   opnd_nxt;
  operand_s   opnd_q;
  logic       ram_we_q;

  // --------------------
  // Address and read source
  assign ram_adr = (dec_i.file == '0) ? {status_i[7], fsr_i}      // Indirect, IRP
                                      : {status_i[6:5], dec_i.file};
  assign offset  = ram_adr[6:0];

  assign addr_sram   = (offset >= `PIC_FIRST_GPR);
  assign addr_pcl    = (offset == `PIC_ADR_PCL);
  assign addr_status = (offset == `PIC_ADR_STATUS);
  assign addr_fsr    = (offset == `PIC_ADR_FSR);
  assign addr_pclath = (offset == `PIC_ADR_PCLATH);

  always_comb
  begin
    if (addr_sram)        rd_data = ram_dat_i;
    else if (addr_pcl)    rd_data = pc_i[7:0];   // PC low byte
    else if (addr_status) rd_data = status_i;
    else if (addr_fsr)    rd_data = fsr_i;
    else if (addr_pclath) rd_data = pclath_i;
    else                  rd_data = '0;          // INDF and unused
  end

  assign mask = data_t'(1'b1) << dec_i.bit_idx;

  // ALU operands
  always_comb
  begin
    opnd_nxt = '0;
    case (dec_i.op)
      OP_MOVLW, OP_ADDLW, OP_SUBLW, OP_ANDLW, OP_IORLW, OP_XORLW, OP_RETLW:
        opnd_nxt.alu_a = dec_i.literal;
      OP_CLRF, OP_CLRW: opnd_nxt.alu_a = '0;
      OP_MOVWF, OP_NOP, OP_CALL, OP_GOTO, OP_RETURN:
        opnd_nxt.alu_a = w_i;
      default: opnd_nxt.alu_a = rd_data;          // Byte and bit ops
    endcase
    case (dec_i.op)
      OP_DECF, OP_DECFSZ: opnd_nxt.alu_b = '1;   // Minus one
      OP_INCF, OP_INCFSZ: opnd_nxt.alu_b = data_t'(1'b1);
      OP_SUBLW, OP_SUBWF:
      begin
        opnd_nxt.alu_b       = ~w_i + 1'b1;      // Two's complement of W
        opnd_nxt.sub_zero_c  = (w_i == '0);
        opnd_nxt.sub_zero_dc = (w_i[3:0] == 4'h0);
      end
      OP_BCF:                       opnd_nxt.alu_b = ~mask;
      OP_BSF, OP_BTFSC, OP_BTFSS:   opnd_nxt.alu_b = mask;
      default:                      opnd_nxt.alu_b = w_i;
    endcase
    opnd_nxt.tgt_pcl    = dec_i.dest_f && addr_pcl;
    opnd_nxt.tgt_status = dec_i.dest_f && addr_status;
    opnd_nxt.tgt_fsr    = dec_i.dest_f && addr_fsr;
    opnd_nxt.tgt_pclath = dec_i.dest_f && addr_pclath;
  end

  // --------------------
  // Q2 registers
  always_ff @(posedge clk_i)
  begin
    if (phase_i == PH_Q2 && !stall_i)
      opnd_q <= opnd_nxt;
  end

  // Write strobe covers exactly the Q4 clock
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      ram_we_q <= 1'b0;
    else if (phase_i == PH_Q2)
      ram_we_q <= !stall_i && dec_i.dest_f && addr_sram;
    else
      ram_we_q <= 1'b0;
  end

  assign opnd_o    = opnd_q;
  assign ram_adr_o = ram_adr;
  assign ram_we_o  = ram_we_q;

endmodule

// ==== hdl/pic_execute.sv ====
module pic_execute (
  input  logic               clk_i,
  input  logic               reset_i,
  input  pic_pkg::phase_e    phase_i,
  input  pic_pkg::decoded_s  dec_i,
  input  pic_pkg::operand_s  opnd_i,
  output pic_pkg::redirect_s redirect_o,
  output logic               stall_o,     // Current cycle executes nothing
  output pic_pkg::data_t     aluout_o,
  output pic_pkg::data_t     w_o,
  output pic_pkg::data_t     status_o,
  output pic_pkg::data_t     fsr_o,
  output pic_pkg::data_t     pclath_o
);
  import pic_pkg::*;

  data_t      aluout;
  logic [8:0] add_full;                  // Carry out in bit 8
  logic [4:0] add_low;                   // Nibble carry in bit 4
  logic       zero;
  logic       skip_taken;
  logic       is_addsub;
  logic       z_op;
  logic       next_stall;
  logic       stall_q;
  redirect_s  redirect;
  data_t      w_q;
  data_t      status_q;                  // IRP RP1 RP0 TO PD Z DC C
  data_t      fsr_q;
  data_t      pclath_q;

  // --------------------
  // ALU
  assign add_full = {1'b0, opnd_i.alu_a} + {1'b0, opnd_i.alu_b};
  assign add_low  = {1'b0, opnd_i.alu_a[3:0]} + {1'b0, opnd_i.alu_b[3:0]};

  always_comb
  begin
    case (dec_i.op)
      OP_RLF:   aluout = {opnd_i.alu_a[6:0], status_q[0]};   // Through C
      OP_RRF:   aluout = {status_q[0], opnd_i.alu_a[7:1]};
      OP_SWAPF: aluout = {opnd_i.alu_a[3:0], opnd_i.alu_a[7:4]};
      OP_COMF:  aluout = ~opnd_i.alu_a;
      OP_ANDLW, OP_ANDWF, OP_BCF, OP_BTFSC, OP_BTFSS:
        aluout = opnd_i.alu_a & opnd_i.alu_b;
      OP_BSF, OP_IORLW, OP_IORWF:
        aluout = opnd_i.alu_a | opnd_i.alu_b;
      OP_XORLW, OP_XORWF:
        aluout = opnd_i.alu_a ^ opnd_i.alu_b;
      OP_ADDLW, OP_ADDWF, OP_SUBLW, OP_SUBWF,
      OP_DECF, OP_DECFSZ, OP_INCF, OP_INCFSZ:
        aluout = add_full[7:0];
      default:  aluout = opnd_i.alu_a;                       // Pass
    endcase
  end

  assign zero      = (aluout == '0);
  assign is_addsub = dec_i.op inside {OP_ADDLW, OP_ADDWF, OP_SUBLW, OP_SUBWF};
  assign z_op      = dec_i.op inside {OP_ADDLW, OP_ADDWF, OP_ANDLW, OP_ANDWF,
                                      OP_CLRF, OP_CLRW, OP_COMF, OP_DECF,
                                      OP_INCF, OP_MOVF, OP_SUBLW, OP_SUBWF,
                                      OP_XORLW, OP_XORWF, OP_IORLW, OP_IORWF};

  // --------------------
  // Redirect and stall
  assign skip_taken = ((dec_i.op inside {OP_BTFSC, OP_DECFSZ, OP_INCFSZ}) && zero)
                   || ((dec_i.op == OP_BTFSS) && !zero);

  always_comb
  begin
    redirect.kind       = RD_NONE;
    redirect.skip_stall = !stall_q && skip_taken;
    redirect.new_pcl    = aluout;
    if (!stall_q)                                  // Stall cycle redirects nothing
    begin
      if (dec_i.op inside {OP_RETURN, OP_RETLW})   redirect.kind = RD_RETURN;
      else if (dec_i.op inside {OP_GOTO, OP_CALL}) redirect.kind = RD_JUMP;
      else if (opnd_i.tgt_pcl)                     redirect.kind = RD_PCL;
    end
  end

  assign next_stall = (redirect.kind != RD_NONE) || redirect.skip_stall;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      stall_q <= 1'b0;
    else if (phase_i == PH_Q4)
      stall_q <= next_stall;
  end

  // --------------------
  // Q4 register writes
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      w_q      <= '0;
      status_q <= 8'h18;                 // TO and PD set, bank 0
      fsr_q    <= '0;
      pclath_q <= '0;
    end
    else if (phase_i == PH_Q4 && !stall_q)
    begin
      if (is_addsub)
      begin
        status_q[1] <= add_low[4] || opnd_i.sub_zero_dc;   // DC
        status_q[0] <= add_full[8] || opnd_i.sub_zero_c;   // C, no borrow
      end
      else if (dec_i.op == OP_RLF) status_q[0] <= opnd_i.alu_a[7];
      else if (dec_i.op == OP_RRF) status_q[0] <= opnd_i.alu_a[0];

      if (dec_i.dest_w) w_q <= aluout;
      if (opnd_i.tgt_status)
      begin
        status_q[7:5] <= aluout[7:5];    // TO and PD read only
        status_q[1:0] <= aluout[1:0];
      end
      if (opnd_i.tgt_fsr)    fsr_q    <= aluout;
      if (opnd_i.tgt_pclath) pclath_q <= {3'b000, aluout[4:0]};

      if (opnd_i.tgt_status) status_q[2] <= aluout[2];
      else if (z_op)         status_q[2] <= zero;
    end
  end

  assign redirect_o = redirect;
  assign stall_o    = stall_q;
  assign aluout_o   = aluout;
  assign w_o        = w_q;
  assign status_o   = status_q;
  assign fsr_o      = fsr_q;
  assign pclath_o   = pclath_q;

endmodule

// ==== hdl/pic_core.sv ====
module pic_core (
  input  logic              clk_i,
  input  logic              reset_i,
  input  pic_pkg::inst_t    prog_dat_i,   // ROM read data
  output pic_pkg::pc_t      prog_adr_o,   // ROM address
  input  pic_pkg::data_t    ram_dat_i,    // RAM read data
  output pic_pkg::data_t    ram_dat_o,    // RAM write data
  output pic_pkg::ram_adr_t ram_adr_o,
  output logic              ram_we_o      // High in Q4 of a RAM write
);
  import pic_pkg::*;

  phase_e    phase;
  inst_t     inst;
  decoded_s  dec;
  operand_s  opnd;
  redirect_s redirect;
  logic      stall;
  data_t     w;
  data_t     status;
  data_t     fsr;
  data_t     pclath;

  // --------------------
  // Fetch, PC and stack
  pic_fetch i_fetch (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .prog_dat_i (prog_dat_i),
    .dec_i      (dec),
    .redirect_i (redirect),
    .stall_i    (stall),
    .pclath_i   (pclath),
    .prog_adr_o (prog_adr_o),
    .inst_o     (inst),
    .phase_o    (phase)
  );

  pic_decode i_decode (
    .inst_i (inst),
    .dec_o  (dec)
  );

  // Q2 operand read
  pic_operand i_operand (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .phase_i   (phase),
    .stall_i   (stall),
    .dec_i     (dec),
    .ram_dat_i (ram_dat_i),
    .w_i       (w),
    .status_i  (status),
    .fsr_i     (fsr),
    .pclath_i  (pclath),
    .pc_i      (prog_adr_o),              // PCL reads see the fetch address
    .opnd_o    (opnd),
    .ram_adr_o (ram_adr_o),
    .ram_we_o  (ram_we_o)
  );

  // Q4 execute and write back
  pic_execute i_execute (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .phase_i    (phase),
    .dec_i      (dec),
    .opnd_i     (opnd),
    .redirect_o (redirect),
    .stall_o    (stall),
    .aluout_o   (ram_dat_o),
    .w_o        (w),
    .status_o   (status),
    .fsr_o      (fsr),
    .pclath_o   (pclath)
  );

endmodule

// ==== verif/tb_clock_gen.sv ====
module tb_clock_gen (
  output logic clk_o,
  output logic reset_o
);

  // 100-unit period
  initial
  begin
    clk_o = 1'b0;
    forever #50 clk_o = ~clk_o;
  end

  // Reset held for 16 cycles, released on a falling edge
  initial
  begin
    reset_o = 1'b1;
    repeat (16) @(posedge clk_o);
    @(negedge clk_o);
    reset_o = 1'b0;
  end

endmodule

// ==== verif/pic_core_tb.sv ====
module pic_core_tb;
  import pic_pkg::*;

  localparam int NUM_CYCLES = 900;       // Instruction cycles after reset
  localparam int MAIN_END   = 'h150;     // Main body stops growing here
  localparam int SUB_BASE   = 'h180;     // Four subroutines 8 words apart
  localparam logic [5:0] BYTE_OPS [13] = '{6'h01, 6'h02, 6'h03, 6'h04, 6'h05, 6'h06,
                                           6'h07, 6'h08, 6'h09, 6'h0A, 6'h0C, 6'h0D, 6'h0E};
  localparam logic [5:0] LIT_OPS [6] = '{6'h30, 6'h3C, 6'h3E, 6'h38, 6'h39, 6'h3A};
  localparam string TEST_NAME [5] = '{"reset", "literal_byte_ops", "bit_ops_skips",
                                      "control_transfers", "indirect_banked"};

  logic     clk;
  logic     reset;
  pc_t      prog_adr;
  inst_t    prog_dat;
  data_t    ram_rd;
  data_t    ram_wr;
  ram_adr_t ram_adr;
  logic     ram_we;

  inst_t rom [1024];
  data_t ram [512];

  // Reference model state
  data_t      m_w;
  data_t      m_st;                      // IRP RP1 RP0 TO PD Z DC C
  data_t      m_fsr;
  data_t      m_pclath;
  pc_t        m_pc;                      // Next instruction to execute
  pc_t        m_stack [8];
  logic [2:0] m_sp;
  data_t      m_ram [512];

  integer seed = 90475;
  int     gp;                            // Program write pointer
  int     chk [5];
  int     err [5];

  tb_clock_gen i_clock_gen (
    .clk_o   (clk),
    .reset_o (reset)
  );

  pic_core i_pic_core (
    .clk_i      (clk),
    .reset_i    (reset),
    .prog_dat_i (prog_dat),
    .prog_adr_o (prog_adr),
    .ram_dat_i  (ram_rd),
    .ram_dat_o  (ram_wr),
    .ram_adr_o  (ram_adr),
    .ram_we_o   (ram_we)
  );

  // --------------------
  // Memories
  assign prog_dat = rom[prog_adr[9:0]];  // 1K words with the upper PC bits unused
  assign ram_rd   = ram[ram_adr];

  always @(posedge clk)
  begin
    if (ram_we)
      ram[ram_adr] <= ram_wr;
  end

  function automatic int rnd(int n);
    return int'(($random(seed) & 32'h7fff_ffff) % n);
  endfunction

  function automatic data_t fill_byte(int a);
    logic [8:0] adr;
    adr = 9'(a);
    return data_t'(adr[7:0] * 8'd29) ^ {adr[8], 7'h35};   // Bank bit folds in
  endfunction

  function automatic logic [6:0] gpr();
    return 7'h0C + 7'(rnd(20));
  endfunction

  task automatic emit(input inst_t i);
    rom[gp[9:0]] = i;
    gp = gp + 1;
  endtask

  function automatic inst_t enc_byte(logic [5:0] opc, logic d, logic [6:0] f);
    return {opc, d, f};
  endfunction

  function automatic inst_t enc_bit(logic [1:0] sel, logic [2:0] b, logic [6:0] f);
    return {2'b01, sel, b, f};           // BCF BSF BTFSC BTFSS
  endfunction

  function automatic inst_t movwf(logic [6:0] f);
    return {7'b0000001, f};
  endfunction

  // --------------------
  // Random program
  task automatic gen_program();
    int r;
    int t;
    for (int i = 0; i < 1024; i++)
      rom[i] = '0;
    gp = 0;
    while (gp < MAIN_END)
    begin
      case (rnd(11))
        0: begin
          emit({LIT_OPS[rnd(6)], 8'(rnd(256))});
          emit(movwf(gpr()));            // Makes W visible
        end
        1: begin
          r = rnd(2);
          emit(enc_byte(BYTE_OPS[rnd(13)], 1'(r), (rnd(4) == 0) ? 7'h00 : gpr()));
          if (r == 0)
            emit(movwf(gpr()));
        end
        2: begin                         // Add or subtract, then store STATUS
          emit(enc_byte((rnd(2) == 0) ? 6'h07 : 6'h02, 1'b0, gpr()));
          emit(enc_byte(6'h08, 1'b0, 7'h03));
          emit(movwf(gpr()));
        end
        3: begin                         // Subtract zero
          emit(14'h0100);
          emit(enc_byte(6'h02, 1'b1, gpr()));
          emit(enc_byte(6'h08, 1'b0, 7'h03));
          emit(movwf(gpr()));
        end
        4: emit(enc_bit(2'(rnd(2)), 3'(rnd(8)), gpr()));
        5: begin                         // Skip over one plain write
          r = rnd(4);
          if (r < 2)
            emit(enc_bit(2'(2 + r), 3'(rnd(8)), gpr()));
          else
            emit(enc_byte((r == 2) ? 6'h0B : 6'h0F, 1'(rnd(2)), gpr()));
          emit(movwf(gpr()));
        end
        6: begin
          r = rnd(3);
          emit({3'b101, 11'(gp + 1 + r)});
          repeat (r) emit(movwf(gpr())); // Jumped over
        end
        7: begin
          emit({3'b100, 11'(SUB_BASE + 8 * rnd(4))});
          emit(movwf(gpr()));            // W from RETLW
        end
        8: begin                         // Computed jump via PCLATH and PCL
          r = rnd(3);
          t = gp + 4 + r;
          emit({6'h30, 8'(t >> 8)});
          emit(movwf(7'h0A));
          emit({6'h30, 8'(t)});
          emit(movwf(7'h02));
          repeat (r) emit(movwf(gpr()));
        end
        9: begin                         // New FSR and IRP
          emit({6'h30, data_t'(gpr()) | ((rnd(2) == 0) ? 8'h00 : 8'h80)});
          emit(movwf(7'h04));
          emit(enc_bit(2'(rnd(2)), 3'd7, 7'h03));
        end
        default: begin                   // Short visit to another bank
          r = 5 + rnd(2);
          emit(enc_bit(2'b01, 3'(r), 7'h03));
          emit(enc_byte(BYTE_OPS[rnd(13)], 1'b1, gpr()));
          emit(enc_bit(2'b00, 3'(r), 7'h03));
        end
      endcase
    end
    emit({3'b101, 11'(gp)});             // Park
    for (int j = 0; j < 4; j++)
    begin
      gp = SUB_BASE + 8 * j;
      repeat (2 + rnd(3))
      begin
        if (rnd(2) == 0)
          emit({LIT_OPS[rnd(6)], 8'(rnd(256))});
        else
          emit(enc_byte(BYTE_OPS[rnd(13)], 1'b1, gpr()));
      end
      if (rnd(2) == 0)
        emit(14'h0008);                  // RETURN
      else
        emit({6'h34, 8'(rnd(256))});     // RETLW
    end
  endtask

  // --------------------
  // Instruction-set model
  function automatic data_t model_read(ram_adr_t a);
    pc_t p;
    p = m_pc + 13'd1;
    if (a[6:0] >= 7'h0C) return m_ram[a];
    case (a[6:0])
      7'h02:   return p[7:0];
      7'h03:   return m_st;
      7'h04:   return m_fsr;
      7'h0A:   return m_pclath;
      default: return 8'h00;
    endcase
  endfunction

  function automatic data_t alu_add(data_t x, data_t y);
    logic [8:0] s;
    s = {1'b0, x} + {1'b0, y};
    m_st[0] = s[8];
    m_st[1] = ({1'b0, x[3:0]} + {1'b0, y[3:0]}) > 5'd15;
    m_st[2] = (s[7:0] == 8'h00);
    return s[7:0];
  endfunction

  function automatic data_t alu_sub(data_t x, data_t y);
    data_t r;
    r = x - y;
    m_st[0] = (x >= y);                  // No borrow
    m_st[1] = (x[3:0] >= y[3:0]);
    m_st[2] = (r == 8'h00);
    return r;
  endfunction

  task automatic model_step(output logic flow, output logic we, output ram_adr_t wadr,
                            output data_t wdat, output int cat);
    inst_t      ins;
    logic [6:0] f;
    ram_adr_t   a;
    data_t      v;
    data_t      res;
    data_t      k;
    logic       wr_f;
    logic       skip;
    pc_t        nxt;
    logic [2:0] b;
    ins  = rom[m_pc[9:0]];
    f    = ins[6:0];
    k    = ins[7:0];
    b    = ins[9:7];
    a    = (f == 7'h00) ? {m_st[7], m_fsr} : {m_st[6:5], f};
    v    = model_read(a);
    nxt  = m_pc + 13'd1;
    res  = 8'h00;
    flow = 1'b0;
    we   = 1'b0;
    wadr = a;
    wdat = 8'h00;
    wr_f = 1'b0;
    skip = 1'b0;
    cat  = 1;
    casez (ins)
      14'b100???????????: begin
        m_stack[m_sp] = m_pc + 13'd1;
        m_sp = m_sp + 3'd1;
        nxt  = {m_pclath[4:3], ins[10:0]};
        flow = 1'b1;
        cat  = 3;
      end
      14'b101???????????: begin
        nxt  = {m_pclath[4:3], ins[10:0]};
        flow = 1'b1;
        cat  = 3;
      end
      14'b01????????????: begin
        cat = 2;
        case (ins[11:10])
          2'd0: begin res = v & ~(8'h01 << b); wr_f = 1'b1; end
          2'd1: begin res = v | (8'h01 << b); wr_f = 1'b1; end
          2'd2: skip = !v[b];
          default: skip = v[b];
        endcase
      end
      14'b1100??????????: m_w = k;
      14'b1101??????????, 14'b00000000001000: begin
        if (ins[13]) m_w = k;            // RETLW
        m_sp = m_sp - 3'd1;
        nxt  = m_stack[m_sp];
        flow = 1'b1;
        cat  = 3;
      end
      14'b11110?????????: m_w = alu_sub(k, m_w);
      14'b11111?????????: m_w = alu_add(k, m_w);
      14'b111000????????: begin m_w = m_w | k; m_st[2] = (m_w == 8'h00); end
      14'b111001????????: begin m_w = m_w & k; m_st[2] = (m_w == 8'h00); end
      14'b111010????????: begin m_w = m_w ^ k; m_st[2] = (m_w == 8'h00); end
      14'b0000000???????: ;              // NOP, RETFIE, SLEEP
      14'b0000001???????: begin res = m_w; wr_f = 1'b1; end
      14'b000001????????: begin          // CLRW, CLRF
        m_st[2] = 1'b1;
        if (ins[7]) wr_f = 1'b1; else m_w = 8'h00;
      end
      14'b00????????????: begin
        case (ins[11:8])
          4'h2: res = alu_sub(v, m_w);
          4'h3: begin res = v - 8'd1; m_st[2] = (res == 8'h00); end
          4'h4: begin res = v | m_w; m_st[2] = (res == 8'h00); end
          4'h5: begin res = v & m_w; m_st[2] = (res == 8'h00); end
          4'h6: begin res = v ^ m_w; m_st[2] = (res == 8'h00); end
          4'h7: res = alu_add(v, m_w);
          4'h8: begin res = v; m_st[2] = (res == 8'h00); end
          4'h9: begin res = ~v; m_st[2] = (res == 8'h00); end
          4'hA: begin res = v + 8'd1; m_st[2] = (res == 8'h00); end
          4'hB: begin res = v - 8'd1; skip = (res == 8'h00); cat = 2; end
          4'hC: begin res = {m_st[0], v[7:1]}; m_st[0] = v[0]; end
          4'hD: begin res = {v[6:0], m_st[0]}; m_st[0] = v[7]; end
          4'hE: res = {v[3:0], v[7:4]};
          default: begin res = v + 8'd1; skip = (res == 8'h00); cat = 2; end
        endcase
        if (ins[7]) wr_f = 1'b1; else m_w = res;
      end
      default: ;
    endcase
    if (skip)
    begin
      nxt  = m_pc + 13'd2;
      flow = 1'b1;
    end
    if (wr_f)
    begin
      if (a[6:0] >= 7'h0C)
      begin
        m_ram[a] = res;
        we       = 1'b1;
        wdat     = res;
        if (f == 7'h00 || a[8:7] != 2'b00) cat = 4;   // Indirect or banked
      end
      else if (a[6:0] == 7'h02)
      begin
        nxt  = {m_pclath[4:0], res};
        flow = 1'b1;
        cat  = 3;
      end
      else if (a[6:0] == 7'h03) m_st = {res[7:5], m_st[4:3], res[2:0]};
      else if (a[6:0] == 7'h04) m_fsr = res;
      else if (a[6:0] == 7'h0A)
      begin
        m_pclath = {3'b000, res[4:0]};
        cat      = 3;
      end
    end
    m_pc = nxt;
  endtask

  // --------------------
  // Checks
  task automatic compare_value(int t, string name, logic [31:0] got, logic [31:0] exp);
    chk[t]++;
    assert (got == exp)
    else
    begin
      $display("ERROR %s got %h expected %h at %0t", name, got, exp, $time);
      err[t]++;
    end
  endtask

  task automatic run_program();
    logic     stall_next;
    logic     flow;
    logic     we;
    ram_adr_t wadr;
    data_t    wdat;
    pc_t      exp_adr;
    int       cat;
    stall_next = 1'b1;                   // Reset NOP behaves like a stall
    cat        = 0;
    for (int n = 0; n < NUM_CYCLES; n++)
    begin
      @(negedge clk);                    // Middle of Q4
      if (stall_next)
      begin
        exp_adr = m_pc;                  // Fetch already at the target
        flow    = 1'b0;
        we      = 1'b0;
      end
      else
      begin
        exp_adr = m_pc + 13'd1;
        model_step(flow, we, wadr, wdat, cat);
      end
      compare_value(cat, "prog_adr_o", 32'(prog_adr), 32'(exp_adr));
      compare_value(cat, "ram_we_o", 32'(ram_we), 32'(we));
      if (we && ram_we)
      begin
        compare_value(cat, "ram_adr_o", 32'(ram_adr), 32'(wadr));
        compare_value(cat, "ram_dat_o", 32'(ram_wr), 32'(wdat));
      end
      stall_next = !stall_next && flow;
      @(posedge clk);                    // End of Q4
      @(negedge clk);                    // Middle of next Q2
      compare_value(cat, "ram_we_o", 32'(ram_we), 32'h0);   // Strobe only in Q4
      @(posedge clk);                    // End of next Q2
    end
  endtask

  // Hard limit on the whole run
  initial
  begin
    #(NUM_CYCLES * 200 + 20000);
    $display("Simulation timed out");
    $display("*** FAILED ***");
    $finish;
  end

  initial
  begin
    int wait_cnt;
    int total_chk;
    int total_err;
    wait_cnt  = 0;
    total_chk = 0;
    total_err = 0;
    for (int i = 0; i < 5; i++)
    begin
      chk[i] = 0;
      err[i] = 0;
    end
    for (int i = 0; i < 512; i++)
    begin
      ram[i]   = fill_byte(i);
      m_ram[i] = fill_byte(i);
    end
    m_w      = 8'h00;
    m_st     = 8'h18;
    m_fsr    = 8'h00;
    m_pclath = 8'h00;
    m_pc     = '0;
    m_sp     = 3'd0;
    for (int i = 0; i < 8; i++)
      m_stack[i] = '0;
    gen_program();

    // Outputs stay quiet during reset
    @(posedge clk);
    while (reset && wait_cnt < 100)
    begin
      @(negedge clk);
      compare_value(0, "ram_we_o", 32'(ram_we), 32'h0);
      compare_value(0, "prog_adr_o", 32'(prog_adr), 32'h0);
      @(posedge clk);
      wait_cnt++;
    end
    if (reset)
    begin
      $display("Reset was never released");
      $display("*** FAILED ***");
      $finish;
    end
    else
    begin
      run_program();
      for (int i = 0; i < 5; i++)
      begin
        $display("test %-18s checks %0d errors %0d", TEST_NAME[i], chk[i], err[i]);
        total_chk += chk[i];
        total_err += err[i];
      end
      $display("total checks %0d errors %0d", total_chk, total_err);
      if (total_err == 0)
        $display("*** PASSED ***");
      else
        $display("*** FAILED ***");
      $finish;
    end
  end

endmodule

// ==== pic_core.f ====
+incdir+include
hdl/pic_pkg.sv
hdl/pic_fetch.sv
hdl/pic_decode.sv
hdl/pic_operand.sv
hdl/pic_execute.sv
hdl/pic_core.sv
verif/tb_clock_gen.sv
verif/pic_core_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module pic_core_tb -f pic_core.f -o pic_core_sim
./obj_dir/pic_core_sim | tee sim.log

if grep -qF "*** PASSED ***" sim.log; then
  echo "Simulation result: pass"
  exit 0
else
  echo "Simulation result: fail"
  exit 1
fi
